// File: logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [15:0] imm_t;

    // primary opcodes, instr[31:26]
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_REGIMM  = 6'b000001;
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_BNE     = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110;
    localparam opcode_t OP_BGTZ    = 6'b000111;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_COP0    = 6'b010000;
    localparam opcode_t OP_LB      = 6'b100000;
    localparam opcode_t OP_LH      = 6'b100001;
    localparam opcode_t OP_LW      = 6'b100011;
    localparam opcode_t OP_LBU     = 6'b100100;
    localparam opcode_t OP_LHU     = 6'b100101;
    localparam opcode_t OP_SB      = 6'b101000;
    localparam opcode_t OP_SH      = 6'b101001;
    localparam opcode_t OP_SW      = 6'b101011;

    // SPECIAL funct codes, instr[5:0]
    localparam funct_t FUN_SLL     = 6'b000000;
    localparam funct_t FUN_SRL     = 6'b000010;
    localparam funct_t FUN_SRA     = 6'b000011;
    localparam funct_t FUN_SLLV    = 6'b000100;
    localparam funct_t FUN_SRLV    = 6'b000110;
    localparam funct_t FUN_SRAV    = 6'b000111;
    localparam funct_t FUN_JR      = 6'b001000;
    localparam funct_t FUN_JALR    = 6'b001001;
    localparam funct_t FUN_SYSCALL = 6'b001100;
    localparam funct_t FUN_BREAK   = 6'b001101;
    localparam funct_t FUN_MFHI    = 6'b010000;
    localparam funct_t FUN_MTHI    = 6'b010001;
    localparam funct_t FUN_MFLO    = 6'b010010;
    localparam funct_t FUN_MTLO    = 6'b010011;
    localparam funct_t FUN_MULT    = 6'b011000;
    localparam funct_t FUN_MULTU   = 6'b011001;
    localparam funct_t FUN_DIV     = 6'b011010;
    localparam funct_t FUN_DIVU    = 6'b011011;
    localparam funct_t FUN_ADD     = 6'b100000;
    localparam funct_t FUN_ADDU    = 6'b100001;
    localparam funct_t FUN_SUB     = 6'b100010;
    localparam funct_t FUN_SUBU    = 6'b100011;
    localparam funct_t FUN_AND     = 6'b100100;
    localparam funct_t FUN_OR      = 6'b100101;
    localparam funct_t FUN_XOR     = 6'b100110;
    localparam funct_t FUN_NOR     = 6'b100111;
    localparam funct_t FUN_SLT     = 6'b101010;
    localparam funct_t FUN_SLTU    = 6'b101011;
    localparam funct_t FUN_ERET    = 6'b011000; // only under COP0 with rs = CO

    // REGIMM branches live in the rt field
    localparam reg_addr_t RT_BLTZ   = 5'b00000;
    localparam reg_addr_t RT_BGEZ   = 5'b00001;
    localparam reg_addr_t RT_BLTZAL = 5'b10000;
    localparam reg_addr_t RT_BGEZAL = 5'b10001;

    // COP0 sub-ops in the rs field
    localparam reg_addr_t RS_MFC0 = 5'b00000;
    localparam reg_addr_t RS_MTC0 = 5'b00100;
    localparam reg_addr_t RS_CO   = 5'b10000;

    localparam reg_addr_t LINK_REG = 5'd31; // $ra

endpackage

`default_nettype wire

// File: logic/decode_pkg.sv
`default_nettype none

package decode_pkg;

    import isa_pkg::*;

    typedef enum logic [7:0] {
        ALU_NOP = 8'h00,
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_LUI,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV,
        ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU, // results go to hi/lo
        ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO,
        ALU_MFC0
    } alu_op_t;

    typedef enum logic [3:0] {
        BT_NOP = 4'd0,
        BT_J, BT_JREG, BT_BEQ, BT_BNE, BT_BGTZ, BT_BLEZ, BT_BGEZ, BT_BLTZ
    } branch_type_t;

    typedef struct packed {
        alu_op_t aluop;
        logic    read_rs;
        logic    read_rt;
        logic    reg_write;
        logic    mem_en;
        logic    mem_read;
        logic    mem_write;
        logic    mem_write_reg;   // load result goes to the gpr file
        logic    cp0_read;
        logic    cp0_write;
        logic    hilo_read;
        logic    hilo_write;
        logic    may_bring_flush; // redirect or exception possible
        logic    only_one_issue;
    } ctrl_sig_t;

    typedef struct packed {
        logic undefined_inst;
        logic syscall_inst;
        logic break_inst;
        logic eret_inst;
        logic cpu_unusable;
    } exc_flags_t;

    typedef struct packed {
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        imm_t      imm;
        word_t     ext_imm;
        word_t     shamt;
        reg_addr_t reg_waddr;
    } operand_t;

    typedef struct packed {
        branch_type_t branch_type;
        logic         is_link_pc8;
    } branch_info_t;

    typedef struct packed {
        ctrl_sig_t    ctrl;
        exc_flags_t   exc;
        operand_t     opnd;
        branch_info_t br;
    } decoded_t;

endpackage

`default_nettype wire

// File: logic/inst_ctrl.sv
`default_nettype none

module inst_ctrl import isa_pkg::*, decode_pkg::*; (
    input  word_t      instr,
    input  logic       c0_useable,
    output ctrl_sig_t  ctrl,
    output exc_flags_t exc
);

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    alu_op_t   aluop;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];

    // alu operation only, flags are below
    always_comb begin
        aluop = ALU_NOP;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FUN_ADD:   aluop = ALU_ADD;
                    FUN_ADDU:  aluop = ALU_ADDU;
                    FUN_SUB:   aluop = ALU_SUB;
                    FUN_SUBU:  aluop = ALU_SUBU;
                    FUN_SLT:   aluop = ALU_SLT;
                    FUN_SLTU:  aluop = ALU_SLTU;
                    FUN_AND:   aluop = ALU_AND;
                    FUN_OR:    aluop = ALU_OR;
                    FUN_XOR:   aluop = ALU_XOR;
                    FUN_NOR:   aluop = ALU_NOR;
                    FUN_SLL:   aluop = ALU_SLL;
                    FUN_SRL:   aluop = ALU_SRL;
                    FUN_SRA:   aluop = ALU_SRA;
                    FUN_SLLV:  aluop = ALU_SLLV;
                    FUN_SRLV:  aluop = ALU_SRLV;
                    FUN_SRAV:  aluop = ALU_SRAV;
                    FUN_MULT:  aluop = ALU_MULT;
                    FUN_MULTU: aluop = ALU_MULTU;
                    FUN_DIV:   aluop = ALU_DIV;
                    FUN_DIVU:  aluop = ALU_DIVU;
                    FUN_MFHI:  aluop = ALU_MFHI;
                    FUN_MFLO:  aluop = ALU_MFLO;
                    FUN_MTHI:  aluop = ALU_MTHI;
                    FUN_MTLO:  aluop = ALU_MTLO;
                    default:   aluop = ALU_NOP;
                endcase
            end
            OP_ADDI:  aluop = ALU_ADD;
            OP_ADDIU: aluop = ALU_ADDU;
            OP_SLTI:  aluop = ALU_SLT;
            OP_SLTIU: aluop = ALU_SLTU;
            OP_ANDI:  aluop = ALU_AND;
            OP_ORI:   aluop = ALU_OR;
            OP_XORI:  aluop = ALU_XOR;
            OP_LUI:   aluop = ALU_LUI;
            OP_COP0:  aluop = (rs == RS_MFC0) ? ALU_MFC0 : ALU_NOP;
            default:  aluop = ALU_NOP;
        endcase
    end

    always_comb begin
        ctrl       = '0;
        ctrl.aluop = aluop;
        exc        = '0;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FUN_ADD, FUN_ADDU, FUN_SUB, FUN_SUBU, FUN_SLT, FUN_SLTU,
                    FUN_AND, FUN_OR, FUN_XOR, FUN_NOR, FUN_SLLV, FUN_SRLV, FUN_SRAV: begin
                        ctrl.read_rs   = 1'b1;
                        ctrl.read_rt   = 1'b1;
                        ctrl.reg_write = 1'b1;
                    end
                    FUN_SLL, FUN_SRL, FUN_SRA: begin // shift by shamt, rs unused
                        ctrl.read_rt   = 1'b1;
                        ctrl.reg_write = 1'b1;
                    end
                    FUN_MULT, FUN_MULTU, FUN_DIV, FUN_DIVU: begin
                        ctrl.read_rs    = 1'b1;
                        ctrl.read_rt    = 1'b1;
                        ctrl.hilo_write = 1'b1;
                    end
                    FUN_MFHI, FUN_MFLO: begin
                        ctrl.hilo_read = 1'b1;
                        ctrl.reg_write = 1'b1;
                    end
                    FUN_MTHI, FUN_MTLO: begin
                        ctrl.read_rs    = 1'b1;
                        ctrl.hilo_write = 1'b1;
                    end
                    FUN_JR, FUN_JALR: begin
                        ctrl.read_rs         = 1'b1;
                        ctrl.may_bring_flush = 1'b1;
                        ctrl.reg_write       = (funct == FUN_JALR); // pc+8 into rd
                    end
                    FUN_SYSCALL, FUN_BREAK: begin
                        exc.syscall_inst     = (funct == FUN_SYSCALL);
                        exc.break_inst       = (funct == FUN_BREAK);
                        ctrl.may_bring_flush = 1'b1;
                        ctrl.only_one_issue  = 1'b1;
                    end
                    default: exc.undefined_inst = 1'b1;
                endcase
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                ctrl.read_rs       = 1'b1;
                ctrl.reg_write     = 1'b1;
                ctrl.mem_en        = 1'b1;
                ctrl.mem_read      = 1'b1;
                ctrl.mem_write_reg = 1'b1;
            end
            OP_SB, OP_SH, OP_SW: begin
                ctrl.read_rs   = 1'b1;
                ctrl.read_rt   = 1'b1; // store data
                ctrl.mem_en    = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
                ctrl.read_rs   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_LUI: ctrl.reg_write = 1'b1;
            OP_J, OP_JAL: begin
                ctrl.may_bring_flush = 1'b1;
                ctrl.reg_write       = (opcode == OP_JAL);
            end
            OP_BEQ, OP_BNE: begin
                ctrl.read_rs         = 1'b1;
                ctrl.read_rt         = 1'b1;
                ctrl.may_bring_flush = 1'b1;
            end
            OP_BGTZ, OP_BLEZ: begin
                ctrl.read_rs         = 1'b1;
                ctrl.may_bring_flush = 1'b1;
            end
            OP_REGIMM: begin
                case (rt)
                    RT_BGEZ, RT_BLTZ, RT_BGEZAL, RT_BLTZAL: begin
                        ctrl.read_rs         = 1'b1;
                        ctrl.may_bring_flush = 1'b1;
                        ctrl.reg_write       = (rt == RT_BGEZAL) || (rt == RT_BLTZAL);
                    end
                    default: exc.undefined_inst = 1'b1;
                endcase
            end
            OP_COP0: begin
                exc.cpu_unusable = ~c0_useable; // any cop0 word in user mode
                case (rs)
                    RS_MFC0: begin
                        ctrl.cp0_read       = 1'b1;
                        ctrl.reg_write      = 1'b1;
                        ctrl.only_one_issue = 1'b1;
                    end
                    RS_MTC0: begin
                        ctrl.read_rt        = 1'b1;
                        ctrl.cp0_write      = 1'b1;
                        ctrl.only_one_issue = 1'b1;
                    end
                    RS_CO: begin
                        if (funct == FUN_ERET) begin
                            exc.eret_inst       = 1'b1;
                            ctrl.only_one_issue = 1'b1;
                        end else begin
                            exc.undefined_inst = 1'b1;
                        end
                    end
                    default: exc.undefined_inst = 1'b1;
                endcase
            end
            default: exc.undefined_inst = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/branch_decode.sv
`default_nettype none

module branch_decode import isa_pkg::*, decode_pkg::*; (
    input  word_t        instr,
    output branch_info_t br
);

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rt;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rt     = instr[20:16];

    always_comb begin
        br.branch_type = BT_NOP;
        br.is_link_pc8 = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                if (funct == FUN_JR || funct == FUN_JALR) begin
                    br.branch_type = BT_JREG;
                    br.is_link_pc8 = (funct == FUN_JALR);
                end
            end
            OP_J, OP_JAL: begin
                br.branch_type = BT_J;
                br.is_link_pc8 = (opcode == OP_JAL);
            end
            OP_BEQ:  br.branch_type = BT_BEQ;
            OP_BNE:  br.branch_type = BT_BNE;
            OP_BGTZ: br.branch_type = BT_BGTZ;
            OP_BLEZ: br.branch_type = BT_BLEZ;
            OP_REGIMM: begin
                case (rt)
                    RT_BGEZ, RT_BGEZAL: br.branch_type = BT_BGEZ;
                    RT_BLTZ, RT_BLTZAL: br.branch_type = BT_BLTZ;
                    default:            br.branch_type = BT_NOP;
                endcase
                br.is_link_pc8 = (rt == RT_BGEZAL) || (rt == RT_BLTZAL); // ra = pc+8
            end
            default: br.branch_type = BT_NOP;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/operand_decode.sv
`default_nettype none

module operand_decode import isa_pkg::*, decode_pkg::*; (
    input  word_t    instr,
    output operand_t opnd
);

    opcode_t   opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    always_comb begin
        opnd.rs    = rs;
        opnd.rt    = rt;
        opnd.rd    = rd;
        opnd.imm   = instr[15:0];
        opnd.shamt = {27'b0, instr[10:6]};
        // andi, ori, xori, lui are the opcodes with bits 3:2 set
        if (opcode[3:2] == 2'b11) begin
            opnd.ext_imm = {16'b0, instr[15:0]};
        end else begin
            opnd.ext_imm = {{16{instr[15]}}, instr[15:0]};
        end
        case (opcode)
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: opnd.reg_waddr = rt;
            OP_JAL:    opnd.reg_waddr = LINK_REG;
            OP_REGIMM: opnd.reg_waddr = (rt == RT_BGEZAL || rt == RT_BLTZAL) ? LINK_REG : rd;
            OP_COP0:   opnd.reg_waddr = (rs == RS_MFC0) ? rt : rd; // mfc0 writes gpr rt
            default:   opnd.reg_waddr = rd;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/id_latch.sv
`default_nettype none

module id_latch import decode_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     instr_valid,
    input  decoded_t d,
    output decoded_t q,
    output logic     q_valid
);

    // flush wins over stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q       <= '0;
            q_valid <= 1'b0;
        end else if (flush) begin
            q_valid <= 1'b0; // payload left as is
        end else if (!stall) begin
            q       <= d;
            q_valid <= instr_valid;
        end
    end

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`default_nettype none

module decode_stage import isa_pkg::*, decode_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    instr,
    input  logic     instr_valid,
    input  logic     c0_useable,
    input  logic     stall,
    input  logic     flush,
    output decoded_t dec,
    output logic     dec_valid
);

    ctrl_sig_t    ctrl;
    exc_flags_t   exc;
    operand_t     opnd;
    branch_info_t br;
    decoded_t     dec_d;

    assign dec_d = '{ctrl: ctrl, exc: exc, opnd: opnd, br: br};

    inst_ctrl i_inst_ctrl (
        .instr      (instr),
        .c0_useable (c0_useable),
        .ctrl       (ctrl),
        .exc        (exc)
    );

    branch_decode i_branch_decode (
        .instr (instr),
        .br    (br)
    );

    operand_decode i_operand_decode (
        .instr (instr),
        .opnd  (opnd)
    );

    // one cycle to the execute stage
    id_latch i_id_latch (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .flush       (flush),
        .instr_valid (instr_valid),
        .d           (dec_d),
        .q           (dec),
        .q_valid     (dec_valid)
    );

endmodule

`default_nettype wire

// File: verif/decode_checker.sv
`default_nettype none

module decode_checker import isa_pkg::*, decode_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    instr,
    input  logic     instr_valid,
    input  logic     c0_useable,
    input  logic     stall,
    input  logic     flush,
    input  decoded_t dec,
    input  logic     dec_valid,
    output int       error_count,
    output int       check_count,
    output int       valid_count
);

    timeunit 1ns;
    timeprecision 1ps;

    // special functs that name an alu operation
    localparam funct_t alu_fn_tab [0:23] = '{
        FUN_ADD, FUN_ADDU, FUN_SUB, FUN_SUBU, FUN_SLT, FUN_SLTU, FUN_AND, FUN_OR,
        FUN_XOR, FUN_NOR, FUN_SLL, FUN_SRL, FUN_SRA, FUN_SLLV, FUN_SRLV, FUN_SRAV,
        FUN_MULT, FUN_MULTU, FUN_DIV, FUN_DIVU, FUN_MFHI, FUN_MFLO, FUN_MTHI, FUN_MTLO
    };
    localparam alu_op_t alu_fn_ops [0:23] = '{
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV,
        ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU, ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO
    };
    // immediate group indexed by opcode bits 2:0
    localparam alu_op_t imm_alu_tab [0:7] = '{
        ALU_ADD, ALU_ADDU, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR, ALU_LUI
    };
    localparam branch_type_t br_cmp_tab [0:3] = '{BT_BEQ, BT_BNE, BT_BLEZ, BT_BGTZ};

    decoded_t exp_q      = '0;
    logic     exp_valid  = 1'b0;
    word_t    exp_instr  = '0;
    logic     reset_seen = 1'b0;
    int       errs       = 0;
    int       checks     = 0;
    int       valids     = 0;

    assign error_count = errs;
    assign check_count = checks;
    assign valid_count = valids;

    function automatic decoded_t ref_decode(word_t w, logic c0_ok);
        decoded_t  e;
        opcode_t   op;
        funct_t    fn;
        reg_addr_t f_rs;
        reg_addr_t f_rt;
        logic      alu_hit;
        op      = w[31:26];
        fn      = w[5:0];
        f_rs    = w[25:21];
        f_rt    = w[20:16];
        alu_hit = 1'b0;
        e       = '0;
        e.opnd.rs        = f_rs;
        e.opnd.rt        = f_rt;
        e.opnd.rd        = w[15:11];
        e.opnd.imm       = w[15:0];
        e.opnd.shamt     = {27'd0, w[10:6]};
        e.opnd.ext_imm   = (op[3:2] == 2'b11) ? {16'd0, w[15:0]} : {{16{w[15]}}, w[15:0]};
        e.opnd.reg_waddr = w[15:11];
        if (op == OP_SPECIAL) begin
            for (int i = 0; i < 24; i++) begin
                if (fn == alu_fn_tab[i]) begin
                    e.ctrl.aluop = alu_fn_ops[i];
                    alu_hit      = 1'b1;
                end
            end
            if (fn inside {FUN_SLL, FUN_SRL, FUN_SRA}) begin
                e.ctrl.read_rt   = 1'b1;
                e.ctrl.reg_write = 1'b1;
            end else if (fn inside {FUN_MULT, FUN_MULTU, FUN_DIV, FUN_DIVU}) begin
                e.ctrl.read_rs    = 1'b1;
                e.ctrl.read_rt    = 1'b1;
                e.ctrl.hilo_write = 1'b1;
            end else if (fn inside {FUN_MFHI, FUN_MFLO}) begin
                e.ctrl.hilo_read = 1'b1;
                e.ctrl.reg_write = 1'b1;
            end else if (fn inside {FUN_MTHI, FUN_MTLO}) begin
                e.ctrl.read_rs    = 1'b1;
                e.ctrl.hilo_write = 1'b1;
            end else if (alu_hit) begin // plain three-register ops
                e.ctrl.read_rs   = 1'b1;
                e.ctrl.read_rt   = 1'b1;
                e.ctrl.reg_write = 1'b1;
            end else if (fn inside {FUN_JR, FUN_JALR}) begin
                e.ctrl.read_rs         = 1'b1;
                e.ctrl.may_bring_flush = 1'b1;
                e.ctrl.reg_write       = (fn == FUN_JALR);
                e.br.branch_type       = BT_JREG;
                e.br.is_link_pc8       = (fn == FUN_JALR);
            end else if (fn inside {FUN_SYSCALL, FUN_BREAK}) begin
                e.exc.syscall_inst     = (fn == FUN_SYSCALL);
                e.exc.break_inst       = (fn == FUN_BREAK);
                e.ctrl.may_bring_flush = 1'b1;
                e.ctrl.only_one_issue  = 1'b1;
            end else begin
                e.exc.undefined_inst = 1'b1;
            end
        end else if (op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU}) begin
            e.ctrl.read_rs       = 1'b1;
            e.ctrl.reg_write     = 1'b1;
            e.ctrl.mem_en        = 1'b1;
            e.ctrl.mem_read      = 1'b1;
            e.ctrl.mem_write_reg = 1'b1;
            e.opnd.reg_waddr     = f_rt;
        end else if (op inside {OP_SB, OP_SH, OP_SW}) begin
            e.ctrl.read_rs   = 1'b1;
            e.ctrl.read_rt   = 1'b1;
            e.ctrl.mem_en    = 1'b1;
            e.ctrl.mem_write = 1'b1;
        end else if (op[5:3] == 3'b001) begin // addi through lui
            e.ctrl.aluop     = imm_alu_tab[op[2:0]];
            e.ctrl.read_rs   = (op != OP_LUI);
            e.ctrl.reg_write = 1'b1;
            e.opnd.reg_waddr = f_rt;
        end else if (op inside {OP_J, OP_JAL}) begin
            e.ctrl.may_bring_flush = 1'b1;
            e.br.branch_type       = BT_J;
            if (op == OP_JAL) begin
                e.ctrl.reg_write = 1'b1;
                e.br.is_link_pc8 = 1'b1;
                e.opnd.reg_waddr = LINK_REG;
            end
        end else if (op[5:2] == 4'b0001) begin // beq bne blez bgtz
            e.ctrl.read_rs         = 1'b1;
            e.ctrl.read_rt         = ~op[1];
            e.ctrl.may_bring_flush = 1'b1;
            e.br.branch_type       = br_cmp_tab[op[1:0]];
        end else if (op == OP_REGIMM) begin
            if (f_rt inside {RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL}) begin
                e.ctrl.read_rs         = 1'b1;
                e.ctrl.may_bring_flush = 1'b1;
                if (f_rt[0]) begin
                    e.br.branch_type = BT_BGEZ;
                end else begin
                    e.br.branch_type = BT_BLTZ;
                end
                if (f_rt[4]) begin // and-link forms
                    e.ctrl.reg_write = 1'b1;
                    e.br.is_link_pc8 = 1'b1;
                    e.opnd.reg_waddr = LINK_REG;
                end
            end else begin
                e.exc.undefined_inst = 1'b1;
            end
        end else if (op == OP_COP0) begin
            e.exc.cpu_unusable = ~c0_ok;
            if (f_rs == RS_MFC0) begin
                e.ctrl.aluop          = ALU_MFC0;
                e.ctrl.cp0_read       = 1'b1;
                e.ctrl.reg_write      = 1'b1;
                e.ctrl.only_one_issue = 1'b1;
                e.opnd.reg_waddr      = f_rt;
            end else if (f_rs == RS_MTC0) begin
                e.ctrl.read_rt        = 1'b1;
                e.ctrl.cp0_write      = 1'b1;
                e.ctrl.only_one_issue = 1'b1;
            end else if (f_rs == RS_CO && fn == FUN_ERET) begin
                e.exc.eret_inst       = 1'b1;
                e.ctrl.only_one_issue = 1'b1;
            end else begin
                e.exc.undefined_inst = 1'b1;
            end
        end else begin
            e.exc.undefined_inst = 1'b1;
        end
        return e;
    endfunction

    task automatic compare_field(input string name, input logic [159:0] got,
                                 input logic [159:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errs = errs + 1;
            $display("ERROR at %0d ns: %s is %0h, expected %0h, instr %h",
                     $time, name, got, exp, exp_instr);
        end
    endtask

    // outputs are read before this edge updates them
    always @(posedge clk) begin
        if (!rst_n) begin
            if (reset_seen) begin
                compare_field("dec_valid in reset", 160'(dec_valid), 160'(0));
                compare_field("dec in reset", 160'(dec), 160'(0));
            end
            reset_seen <= 1'b1;
            exp_q      <= '0;
            exp_valid  <= 1'b0;
            exp_instr  <= '0;
        end else begin
            compare_field("dec_valid", 160'(dec_valid), 160'(exp_valid));
            compare_field("aluop", 160'(dec.ctrl.aluop), 160'(exp_q.ctrl.aluop));
            compare_field("ctrl", 160'(dec.ctrl), 160'(exp_q.ctrl));
            compare_field("exc", 160'(dec.exc), 160'(exp_q.exc));
            compare_field("reg_waddr", 160'(dec.opnd.reg_waddr), 160'(exp_q.opnd.reg_waddr));
            compare_field("ext_imm", 160'(dec.opnd.ext_imm), 160'(exp_q.opnd.ext_imm));
            compare_field("opnd", 160'(dec.opnd), 160'(exp_q.opnd));
            compare_field("br", 160'(dec.br), 160'(exp_q.br));
            if (dec_valid) valids = valids + 1;
            if (flush) begin
                exp_valid <= 1'b0; // payload holds
            end else if (!stall) begin
                exp_q     <= ref_decode(instr, c0_useable);
                exp_valid <= instr_valid;
                exp_instr <= instr;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_decode.sv
`default_nettype none

module tb_decode import isa_pkg::*, decode_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_instr   = 2000;
    localparam int max_cycles  = 20000;
    localparam int drain_limit = 20;

    // kept opcodes drawn most of the time
    localparam opcode_t op_tab [0:24] = '{
        OP_SPECIAL, OP_REGIMM, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        OP_COP0, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW
    };
    localparam funct_t fn_tab [0:27] = '{
        FUN_SLL, FUN_SRL, FUN_SRA, FUN_SLLV, FUN_SRLV, FUN_SRAV, FUN_JR, FUN_JALR,
        FUN_SYSCALL, FUN_BREAK, FUN_MFHI, FUN_MTHI, FUN_MFLO, FUN_MTLO,
        FUN_MULT, FUN_MULTU, FUN_DIV, FUN_DIVU, FUN_ADD, FUN_ADDU, FUN_SUB, FUN_SUBU,
        FUN_AND, FUN_OR, FUN_XOR, FUN_NOR, FUN_SLT, FUN_SLTU
    };
    localparam reg_addr_t rt_tab [0:3] = '{RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL};
    localparam reg_addr_t rs_tab [0:3] = '{RS_MFC0, RS_MTC0, RS_CO, RS_CO};

    logic        clk = 1'b0;
    logic        rst_n;
    word_t       instr;
    logic        instr_valid;
    logic        c0_useable;
    logic        stall;
    logic        flush;
    decoded_t    dec;
    logic        dec_valid;
    int          error_count;
    int          check_count;
    int          valid_count;
    logic [31:0] rng_state = 32'h29ab;

    always #10 clk = ~clk;

    function logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function word_t make_instr();
        logic [31:0] r_op;
        logic [31:0] r_ctl;
        logic [31:0] r_body;
        word_t       w;
        int          idx;
        r_op   = next_rand();
        r_ctl  = next_rand();
        r_body = next_rand();
        idx    = int'(r_op[22:15]) % 25;
        w      = {op_tab[idx], r_body[25:0]};
        if (r_op[31:29] == 3'd0) begin
            w[31:26] = r_op[28:23]; // mostly undefined raw opcode
        end
        idx = int'(r_ctl[31:24]) % 28;
        case (w[31:26])
            OP_SPECIAL: if (r_ctl[23:22] != 2'd0) w[5:0] = fn_tab[idx];
            OP_REGIMM:  if (r_ctl[21]) w[20:16] = rt_tab[r_ctl[20:19]];
            OP_COP0: begin
                if (r_ctl[18]) w[25:21] = rs_tab[r_ctl[17:16]];
                if (r_ctl[15]) w[5:0] = FUN_ERET;
            end
            default: ;
        endcase
        return w;
    endfunction

    decode_stage i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .c0_useable  (c0_useable),
        .stall       (stall),
        .flush       (flush),
        .dec         (dec),
        .dec_valid   (dec_valid)
    );

    decode_checker i_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .c0_useable  (c0_useable),
        .stall       (stall),
        .flush       (flush),
        .dec         (dec),
        .dec_valid   (dec_valid),
        .error_count (error_count),
        .check_count (check_count),
        .valid_count (valid_count)
    );

    initial begin
        logic [31:0] r;
        int          issued;
        int          cycles;
        int          drain;
        logic        timed_out;
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        c0_useable  = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        issued      = 0;
        cycles      = 0;
        timed_out   = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        while (issued < num_instr && cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
            if (instr_valid && !stall && !flush) issued++; // taken at this edge
            r = next_rand();
            if (!stall) begin // source holds its word while stalled
                instr       <= make_instr();
                instr_valid <= (r[31:30] != 2'b00);
                c0_useable  <= (r[29:28] != 2'b00);
            end
            stall <= (r[27:25] == 3'd0);
            flush <= (r[24:21] == 4'd0);
        end
        if (issued < num_instr) begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d instructions issued in %0d cycles",
                     issued, num_instr, cycles);
        end

        @(posedge clk);
        instr_valid <= 1'b0;
        stall       <= 1'b0;
        flush       <= 1'b0;
        drain = 0;
        while (dec_valid !== 1'b0 && drain < drain_limit) begin
            @(posedge clk);
            drain++;
        end
        if (dec_valid !== 1'b0) begin
            timed_out = 1'b1;
            $display("timeout: dec_valid still high %0d cycles after the input went idle",
                     drain_limit);
        end
        repeat (2) @(posedge clk); // let the checker see the last output

        if (valid_count == 0) begin
            $display("no valid output ever appeared on dec_valid");
        end
        $display("errors: %0d, checks: %0d, valid outputs: %0d, instructions: %0d",
                 error_count, check_count, valid_count, issued);
        if (error_count == 0 && !timed_out && valid_count > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
logic/isa_pkg.sv
logic/decode_pkg.sv
logic/inst_ctrl.sv
logic/branch_decode.sv
logic/operand_decode.sv
logic/id_latch.sv
logic/decode_stage.sv
verif/decode_checker.sv
verif/tb_decode.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 -f src.f --top-module tb_decode -Mdir obj_dir -o sim_decode; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_decode)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
